//--- verilog.f
+incdir+.
axi_ls_bus_pkg.sv
axi_ls_lsu_pkg.sv
axi_ls_rd_engine.sv
axi_ls_wr_engine.sv
axi_ls_lsu.sv
axi_ls_top.sv
axi_ls_props.sv
axi_ls_tb.sv

//--- axi_ls_tb.sv
`timescale 1ns/1ps
`include "axi_ls_config.svh"

module axi_ls_tb;
    import axi_ls_bus_pkg::*;
    import axi_ls_lsu_pkg::*;

    localparam int MAX_CYCLES = 60 * 20;    // tests times per-test limit
    localparam logic [63:0] DWORD_VALUE = 64'h0123_4567_89ab_cdef;

    logic       clock;
    logic       reset;
    logic       req_valid_i;
    logic       req_write_i;
    lsu_addr_t  req_addr_i;
    lsu_width_e req_width_i;
    logic       req_signed_i;
    lsu_data_t  req_wdata_i;
    logic       busy_o;
    logic       done_o;
    lsu_data_t  rdata_o;
    logic       err_o;
    logic       arready_i;
    logic       arvalid_o;
    axi_addr_t  araddr_o;
    axi_size_t  arsize_o;
    logic       rvalid_i;
    logic       rready_o;
    axi_data_t  rdata_i;
    axi_resp_t  rresp_i;
    logic       awready_i;
    logic       awvalid_o;
    axi_addr_t  awaddr_o;
    axi_size_t  awsize_o;
    logic       wready_i;
    logic       wvalid_o;
    axi_data_t  wdata_o;
    axi_strb_t  wstrb_o;
    logic       wlast_o;
    logic       bvalid_i;
    logic       bready_o;
    axi_resp_t  bresp_i;

    logic [63:0] mem [64];      // slave memory indexed by addr[8:3]
    lsu_lanes_u  slave_word;
    axi_size_t   seen_size;     // axsize of the last address phase
    logic        seen_last;     // wlast of the last write beat
    logic [31:0] lcg_state = 32'd48;
    int          cycle_count = 0;

    axi_ls_top axi_ls_top_i (.*);

    bind axi_ls_top axi_ls_props axi_ls_props_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [1:0] rand_delay();
        logic [31:0] r;
        r = lcg_next();
        return r[17:16];    // upper bits since low ones repeat too soon
    endfunction

    // lane from a bus word with sign or zero fill above it
    function automatic logic [63:0] expect_load(logic [63:0] word, logic [2:0] offs,
                                                lsu_width_e width, logic sgn);
        logic [63:0] keep;
        logic [63:0] lane;
        case (width)
            LSU_BYTE: keep = 64'h0000_0000_0000_00ff;
            LSU_HALF: keep = 64'h0000_0000_0000_ffff;
            LSU_WORD: keep = 64'h0000_0000_ffff_ffff;
            default:  keep = '1;
        endcase
        lane = (word >> {offs, 3'b000}) & keep;
        if (sgn && ((lane & ~(keep >> 1)) != 0)) begin
            lane = lane | ~keep;    // top bit of the lane set
        end
        return lane;
    endfunction

    function automatic logic [63:0] merge_store(logic [63:0] old, logic [63:0] data,
                                                logic [2:0] offs, lsu_width_e width);
        logic [63:0] result;
        int          count;
        int          b;
        result = old;
        count  = 1 << int'(width);
        for (b = 0; b < count; b++) begin
            result[8 * (int'(offs) + b) +: 8] = data[8 * b +: 8];
        end
        return result;
    endfunction

    task automatic check_value(input string test, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", test, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // read channel of the slave model
    always begin : read_slave
        logic [31:0] addr;
        @(negedge clock);
        if (arvalid_o) begin
            repeat (rand_delay()) @(negedge clock);
            arready_i = 1'b1;
            addr      = araddr_o;
            seen_size = arsize_o;
            @(negedge clock);
            arready_i = 1'b0;
            while (!rready_o) @(negedge clock);
            repeat (rand_delay()) @(negedge clock);
            rvalid_i = 1'b1;
            if (addr < 32'h400) begin
                rdata_i = mem[addr[8:3]];
                rresp_i = RESP_OKAY;
            end else begin
                rdata_i = 64'hbad0_bad0_bad0_bad0;  // must not reach rdata_o
                rresp_i = RESP_DECERR;
            end
            @(negedge clock);   // rready already high
            rvalid_i = 1'b0;
        end
    end

    // write channels of the slave model
    always begin : write_slave
        logic [31:0] addr;
        int          b;
        @(negedge clock);
        if (awvalid_o) begin
            repeat (rand_delay()) @(negedge clock);
            awready_i = 1'b1;
            addr      = awaddr_o;
            seen_size = awsize_o;
            @(negedge clock);
            awready_i = 1'b0;
            while (!wvalid_o) @(negedge clock);
            repeat (rand_delay()) @(negedge clock);
            wready_i  = 1'b1;
            seen_last = wlast_o;
            if (addr < 32'h400) begin
                slave_word.dword = mem[addr[8:3]];
                for (b = 0; b < 8; b++) begin
                    if (wstrb_o[b]) slave_word.bytes[b] = wdata_o[8 * b +: 8];
                end
                mem[addr[8:3]] = slave_word.dword;
            end
            @(negedge clock);
            wready_i = 1'b0;
            while (!bready_o) @(negedge clock);
            repeat (rand_delay()) @(negedge clock);
            bvalid_i = 1'b1;
            bresp_i  = (addr < 32'h400) ? RESP_OKAY : RESP_DECERR;
            @(negedge clock);
            bvalid_i = 1'b0;
        end
    end

    // one request started on a falling edge
    task automatic do_access(input string name, input logic write, input logic [31:0] addr,
                             input lsu_width_e width, input logic sgn,
                             input logic [63:0] wdata, output logic [63:0] rdata,
                             output logic err);
        int waited;
        while (busy_o) @(negedge clock);
        req_valid_i  = 1'b1;
        req_write_i  = write;
        req_addr_i   = addr;
        req_width_i  = width;
        req_signed_i = sgn;
        req_wdata_i  = wdata;
        @(negedge clock);
        req_valid_i = 1'b0;
        waited      = 0;
        while (!done_o && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (!done_o) begin
            $display("%s: done_o did not arrive within 20 cycles", name);
            $display("Test failed");
            $fatal(1, "no done");
        end
        rdata = rdata_o;
        err   = err_o;
        check_value(name, int'(width), seen_size);   // log2 of the byte count
        if (write) begin
            check_value(name, 1'b1, seen_last);
        end
        @(negedge clock);
    endtask

    task automatic reset_levels();
        check_value("reset_levels", 7'd0,
                    {busy_o, done_o, arvalid_o, rready_o, awvalid_o, wvalid_o, bready_o});
    endtask

    task automatic dword_roundtrip();
        logic [63:0] rdata;
        logic        err;
        do_access("dword_roundtrip", 1'b1, 32'h100, LSU_DWORD, 1'b0, DWORD_VALUE, rdata, err);
        check_value("dword_roundtrip", 1'b0, err);
        do_access("dword_roundtrip", 1'b0, 32'h100, LSU_DWORD, 1'b0, '0, rdata, err);
        check_value("dword_roundtrip", DWORD_VALUE, rdata);
        check_value("dword_roundtrip", 1'b0, err);
    endtask

    task automatic byte_lane_stores();
        logic [63:0] expected;
        logic [63:0] wdata;
        logic [63:0] rdata;
        logic        err;
        int          offs;
        expected = mem[9];
        for (offs = 0; offs < 8; offs++) begin
            wdata    = {56'ha5_a5a5_a5a5_a5a5, 5'h1a, offs[2:0]};  // junk above the byte
            expected = merge_store(expected, wdata, offs[2:0], LSU_BYTE);
            do_access("byte_lanes", 1'b1, 32'h48 + offs, LSU_BYTE, 1'b0, wdata, rdata, err);
            check_value("byte_lanes", 1'b0, err);
            check_value("byte_lanes", expected, mem[9]);
        end
    endtask

    task automatic load_extension();
        logic [63:0] word;
        logic [63:0] rdata;
        logic        err;
        lsu_width_e  widths [8];
        int          offsets [8];
        logic [7:0]  signs;
        int          i;
        word    = 64'hf0e1_d2c3_7b6a_5948;
        widths  = '{LSU_BYTE, LSU_BYTE, LSU_BYTE, LSU_HALF, LSU_HALF, LSU_HALF,
                    LSU_WORD, LSU_WORD};
        offsets = '{5, 5, 2, 6, 6, 2, 4, 4};
        signs   = 8'b0110_1101;
        do_access("load_extend", 1'b1, 32'h88, LSU_DWORD, 1'b0, word, rdata, err);
        for (i = 0; i < 8; i++) begin
            do_access("load_extend", 1'b0, 32'h88 + offsets[i], widths[i], signs[i], '0,
                      rdata, err);
            check_value("load_extend", expect_load(word, offsets[i], widths[i], signs[i]),
                        rdata);
            check_value("load_extend", 1'b0, err);
        end
    endtask

    task automatic decode_error();
        logic [63:0] snap [64];
        logic [63:0] rdata;
        logic        err;
        int          i;
        snap = mem;
        do_access("decode_error", 1'b1, 32'h410, LSU_DWORD, 1'b0, '1, rdata, err);
        check_value("decode_error", 1'b1, err);
        check_value("decode_error", '0, rdata);
        do_access("decode_error", 1'b0, 32'h7f8, LSU_DWORD, 1'b1, '0, rdata, err);
        check_value("decode_error", 1'b1, err);
        check_value("decode_error", '0, rdata);
        for (i = 0; i < 64; i++) begin
            check_value("decode_error", snap[i], mem[i]);
        end
    endtask

    task automatic busy_pulse_ignored();
        logic [63:0] first_data;
        int          dones;
        int          i;
        dones = 0;
        while (busy_o) @(negedge clock);
        req_valid_i  = 1'b1;
        req_write_i  = 1'b0;
        req_addr_i   = 32'h100;
        req_width_i  = LSU_DWORD;
        req_signed_i = 1'b0;
        @(negedge clock);
        req_valid_i = 1'b0;
        check_value("busy_ignore", 1'b1, busy_o);
        req_valid_i = 1'b1;     // store while busy must be dropped
        req_write_i = 1'b1;
        req_wdata_i = '0;
        @(negedge clock);
        req_valid_i = 1'b0;
        for (i = 0; i < 30; i++) begin
            if (done_o) begin
                dones++;
                first_data = rdata_o;
            end
            @(negedge clock);
        end
        check_value("busy_ignore", 1, dones);
        check_value("busy_ignore", DWORD_VALUE, first_data);
        check_value("busy_ignore", DWORD_VALUE, mem[32]);
    endtask

    task automatic random_burst();
        logic [31:0] r;
        logic [31:0] addr;
        logic [63:0] wdata;
        logic [63:0] old;
        logic [63:0] rdata;
        lsu_width_e  width;
        logic        write;
        logic        sgn;
        logic        err;
        int          n;
        for (n = 0; n < 40; n++) begin
            r     = lcg_next();
            width = lsu_width_e'(r[17:16]);
            write = r[18];
            sgn   = r[19];
            addr  = (lcg_next() >> 12) & 32'h3ff;
            addr  = addr & ~((32'd1 << int'(width)) - 32'd1);     // natural alignment
            wdata = {lcg_next(), lcg_next()};
            old   = mem[addr[8:3]];
            do_access("random_burst", write, addr, width, sgn, wdata, rdata, err);
            check_value("random_burst", 1'b0, err);
            if (write) begin
                check_value("random_burst", merge_store(old, wdata, addr[2:0], width),
                            mem[addr[8:3]]);
                check_value("random_burst", '0, rdata);
            end else begin
                check_value("random_burst", expect_load(old, addr[2:0], width, sgn), rdata);
            end
        end
    endtask

    initial begin
        reset        = 1'b0;
        req_valid_i  = 1'b0;
        req_write_i  = 1'b0;
        req_addr_i   = '0;
        req_width_i  = LSU_BYTE;
        req_signed_i = 1'b0;
        req_wdata_i  = '0;
        arready_i    = 1'b0;
        rvalid_i     = 1'b0;
        rdata_i      = '0;
        rresp_i      = RESP_OKAY;
        awready_i    = 1'b0;
        wready_i     = 1'b0;
        bvalid_i     = 1'b0;
        bresp_i      = RESP_OKAY;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {32'h9e37_79b9 * (i + 1), 32'h7f4a_7c15 ^ (i * 32'h0101_0101)};
        end
        repeat (5) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        reset_levels();
        dword_roundtrip();
        byte_lane_stores();
        load_extension();
        decode_error();
        busy_pulse_ignored();
        random_burst();
        $display("Test passed");
        $finish;
    end

endmodule

//--- axi_ls_props.sv
`timescale 1ns/1ps
`include "axi_ls_config.svh"

module axi_ls_props (
    input logic                    clock,
    input logic                    reset,
    input logic                    arvalid_o,
    input logic                    arready_i,
    input logic [`AXLS_ADDR_W-1:0] araddr_o,
    input logic                    awvalid_o,
    input logic                    awready_i,
    input logic [`AXLS_ADDR_W-1:0] awaddr_o,
    input logic                    wvalid_o,
    input logic                    done_o
);

    // valid and address hold until the slave takes them
    ar_hold: assert property (@(posedge clock) disable iff (!reset)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
        else $error("arvalid_o or araddr_o changed before arready_i");

    aw_hold: assert property (@(posedge clock) disable iff (!reset)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
        else $error("awvalid_o or awaddr_o changed before awready_i");

    done_single: assert property (@(posedge clock) disable iff (!reset)
        done_o |=> !done_o)
        else $error("done_o stayed high for two cycles");

    // data phase only after the address phase
    aw_before_w: assert property (@(posedge clock) disable iff (!reset)
        !(wvalid_o && awvalid_o))
        else $error("wvalid_o and awvalid_o high together");

endmodule

//--- axi_ls_top.sv
`timescale 1ns/1ps

module axi_ls_top (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       req_valid_i,
    input  logic                       req_write_i,
    input  axi_ls_lsu_pkg::lsu_addr_t  req_addr_i,
    input  axi_ls_lsu_pkg::lsu_width_e req_width_i,
    input  logic                       req_signed_i,
    input  axi_ls_lsu_pkg::lsu_data_t  req_wdata_i,
    output logic                       busy_o,
    output logic                       done_o,
    output axi_ls_lsu_pkg::lsu_data_t  rdata_o,
    output logic                       err_o,
    input  logic                       arready_i,
    output logic                       arvalid_o,
    output axi_ls_bus_pkg::axi_addr_t  araddr_o,
    output axi_ls_bus_pkg::axi_size_t  arsize_o,
    input  logic                       rvalid_i,
    output logic                       rready_o,
    input  axi_ls_bus_pkg::axi_data_t  rdata_i,
    input  axi_ls_bus_pkg::axi_resp_t  rresp_i,
    input  logic                       awready_i,
    output logic                       awvalid_o,
    output axi_ls_bus_pkg::axi_addr_t  awaddr_o,
    output axi_ls_bus_pkg::axi_size_t  awsize_o,
    input  logic                       wready_i,
    output logic                       wvalid_o,
    output axi_ls_bus_pkg::axi_data_t  wdata_o,
    output axi_ls_bus_pkg::axi_strb_t  wstrb_o,
    output logic                       wlast_o,
    input  logic                       bvalid_i,
    output logic                       bready_o,
    input  axi_ls_bus_pkg::axi_resp_t  bresp_i
);
    import axi_ls_bus_pkg::*;

    logic      rd_start;
    logic      wr_start;
    axi_addr_t bus_addr;    // aligned to the bus word
    axi_size_t bus_size;
    axi_data_t bus_wdata;
    axi_strb_t bus_wstrb;
    logic      rd_done;
    axi_data_t rd_data;
    axi_resp_t rd_resp;
    logic      wr_done;
    axi_resp_t wr_resp;

    // cpu ports and clock/reset by name
    axi_ls_lsu axi_ls_lsu_i (
        .rd_start_o  (rd_start),
        .wr_start_o  (wr_start),
        .bus_addr_o  (bus_addr),
        .bus_size_o  (bus_size),
        .bus_wdata_o (bus_wdata),
        .bus_wstrb_o (bus_wstrb),
        .rd_done_i   (rd_done),
        .rd_data_i   (rd_data),
        .rd_resp_i   (rd_resp),
        .wr_done_i   (wr_done),
        .wr_resp_i   (wr_resp),
        .*
    );

    // ar and r channels
    axi_ls_rd_engine axi_ls_rd_engine_i (
        .start_i (rd_start),
        .addr_i  (bus_addr),
        .size_i  (bus_size),
        .done_o  (rd_done),
        .data_o  (rd_data),
        .resp_o  (rd_resp),
        .*
    );

    // aw, w and b channels
    axi_ls_wr_engine axi_ls_wr_engine_i (
        .start_i (wr_start),
        .addr_i  (bus_addr),
        .size_i  (bus_size),
        .wdata_i (bus_wdata),
        .wstrb_i (bus_wstrb),
        .done_o  (wr_done),
        .resp_o  (wr_resp),
        .*
    );

endmodule

//--- axi_ls_lsu.sv
`timescale 1ns/1ps
`include "axi_ls_config.svh"

module axi_ls_lsu (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       req_valid_i,
    input  logic                       req_write_i,
    input  axi_ls_lsu_pkg::lsu_addr_t  req_addr_i,
    input  axi_ls_lsu_pkg::lsu_width_e req_width_i,
    input  logic                       req_signed_i,
    input  axi_ls_lsu_pkg::lsu_data_t  req_wdata_i,
    input  logic                       rd_done_i,
    input  axi_ls_bus_pkg::axi_data_t  rd_data_i,
    input  axi_ls_bus_pkg::axi_resp_t  rd_resp_i,
    input  logic                       wr_done_i,
    input  axi_ls_bus_pkg::axi_resp_t  wr_resp_i,
    output logic                       busy_o,
    output logic                       rd_start_o,
    output logic                       wr_start_o,
    output axi_ls_bus_pkg::axi_addr_t  bus_addr_o,
    output axi_ls_bus_pkg::axi_size_t  bus_size_o,
    output axi_ls_bus_pkg::axi_data_t  bus_wdata_o,
    output axi_ls_bus_pkg::axi_strb_t  bus_wstrb_o,
    output logic                       done_o,
    output axi_ls_lsu_pkg::lsu_data_t  rdata_o,
    output logic                       err_o
);
    import axi_ls_bus_pkg::*;
    import axi_ls_lsu_pkg::*;

    logic                    accept;
    logic                    start_q;
    logic                    write_q;
    logic                    signed_q;
    lsu_width_e              width_q;
    lsu_addr_t               addr_q;
    logic [`AXLS_OFFS_W-1:0] offs;
    lsu_lanes_u              lanes;
    logic [31:0]             load_word;
    lsu_data_t               load_data;
    axi_resp_t               resp;
    logic                    err;

    assign accept = req_valid_i && !busy_o;   // pulses while busy are dropped
    assign offs   = addr_q[`AXLS_OFFS_W-1:0];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            busy_o  <= 1'b0;
            start_q <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            start_q <= accept;
            done_o  <= rd_done_i || wr_done_i;
            if (accept) begin
                busy_o <= 1'b1;
            end else if (done_o) begin
                busy_o <= 1'b0;   // free again the cycle after done
            end
        end
    end

    // capture request, store data and strobe shifted onto their lanes
    always_ff @(posedge clock) begin
        if (accept) begin
            write_q     <= req_write_i;
            signed_q    <= req_signed_i;
            width_q     <= req_width_i;
            addr_q      <= req_addr_i;
            bus_wdata_o <= req_wdata_i << {req_addr_i[`AXLS_OFFS_W-1:0], 3'b000};
            bus_wstrb_o <= lsu_width_mask(req_width_i) << req_addr_i[`AXLS_OFFS_W-1:0];
        end
    end

    assign rd_start_o = start_q && !write_q;
    assign wr_start_o = start_q && write_q;
    assign bus_addr_o = {addr_q[`AXLS_ADDR_W-1:`AXLS_OFFS_W], {`AXLS_OFFS_W{1'b0}}};

    always_comb begin
        case (width_q)
            LSU_BYTE: bus_size_o = SIZE_1B;
            LSU_HALF: bus_size_o = SIZE_2B;
            LSU_WORD: bus_size_o = SIZE_4B;
            default:  bus_size_o = SIZE_8B;
        endcase
    end

    // pick the loaded lane and extend it
    always_comb begin
        lanes.dword = rd_data_i;
        load_word   = offs[2] ? lanes.dword[63:32] : lanes.dword[31:0];
        case (width_q)
            LSU_BYTE: load_data = {{56{signed_q & lanes.bytes[offs][7]}}, lanes.bytes[offs]};
            LSU_HALF: load_data = {{48{signed_q & lanes.halves[offs[2:1]][15]}},
                                   lanes.halves[offs[2:1]]};
            LSU_WORD: load_data = {{32{signed_q & load_word[31]}}, load_word};
            default:  load_data = lanes.dword;
        endcase
    end

    assign resp = wr_done_i ? wr_resp_i : rd_resp_i;
    assign err  = (resp == RESP_SLVERR) || (resp == RESP_DECERR);

    always_ff @(posedge clock) begin
        if (rd_done_i || wr_done_i) begin
            err_o   <= err;
            rdata_o <= (wr_done_i || err) ? '0 : load_data;   // zero for stores and faults
        end
    end

endmodule

//--- axi_ls_wr_engine.sv
`timescale 1ns/1ps

module axi_ls_wr_engine (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start_i,
    input  axi_ls_bus_pkg::axi_addr_t addr_i,
    input  axi_ls_bus_pkg::axi_size_t size_i,
    input  axi_ls_bus_pkg::axi_data_t wdata_i,
    input  axi_ls_bus_pkg::axi_strb_t wstrb_i,
    input  logic                      awready_i,
    input  logic                      wready_i,
    input  logic                      bvalid_i,
    input  axi_ls_bus_pkg::axi_resp_t bresp_i,
    output logic                      awvalid_o,
    output axi_ls_bus_pkg::axi_addr_t awaddr_o,
    output axi_ls_bus_pkg::axi_size_t awsize_o,
    output logic                      wvalid_o,
    output axi_ls_bus_pkg::axi_data_t wdata_o,
    output axi_ls_bus_pkg::axi_strb_t wstrb_o,
    output logic                      wlast_o,
    output logic                      bready_o,
    output logic                      done_o,
    output axi_ls_bus_pkg::axi_resp_t resp_o
);
    import axi_ls_bus_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;
    localparam logic [1:0] ST_RESP = 2'd3;

    logic [1:0] state_q;
    logic [1:0] state_d;
    axi_addr_t  addr_q;
    axi_size_t  size_q;
    axi_data_t  data_q;
    axi_strb_t  strb_q;

    // aw first, then w, then wait on b
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i) state_d = ST_ADDR;
            end
            ST_ADDR: begin
                if (awready_i) state_d = ST_DATA;
            end
            ST_DATA: begin
                if (wready_i) state_d = ST_RESP;
            end
            ST_RESP: begin
                if (bvalid_i) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
            done_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_o  <= (state_q == ST_RESP) && bvalid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (start_i && state_q == ST_IDLE) begin
            addr_q <= addr_i;
            size_q <= size_i;
            data_q <= wdata_i;   // already on its lanes
            strb_q <= wstrb_i;
        end
        if (state_q == ST_RESP && bvalid_i) begin
            resp_o <= bresp_i;
        end
    end

    assign awvalid_o = (state_q == ST_ADDR);
    assign awaddr_o  = addr_q;
    assign awsize_o  = size_q;

    assign wvalid_o  = (state_q == ST_DATA);
    assign wdata_o   = data_q;
    assign wstrb_o   = strb_q;
    assign wlast_o   = wvalid_o;    // single beat

    assign bready_o  = (state_q == ST_RESP);   // held for the whole b phase

endmodule

//--- axi_ls_rd_engine.sv
`timescale 1ns/1ps

module axi_ls_rd_engine (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start_i,
    input  axi_ls_bus_pkg::axi_addr_t addr_i,
    input  axi_ls_bus_pkg::axi_size_t size_i,
    input  logic                      arready_i,
    input  logic                      rvalid_i,
    input  axi_ls_bus_pkg::axi_data_t rdata_i,
    input  axi_ls_bus_pkg::axi_resp_t rresp_i,
    output logic                      arvalid_o,
    output axi_ls_bus_pkg::axi_addr_t araddr_o,
    output axi_ls_bus_pkg::axi_size_t arsize_o,
    output logic                      rready_o,
    output logic                      done_o,
    output axi_ls_bus_pkg::axi_data_t data_o,
    output axi_ls_bus_pkg::axi_resp_t resp_o
);
    import axi_ls_bus_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;

    logic [1:0] state_q;
    logic [1:0] state_d;
    axi_addr_t  addr_q;
    axi_size_t  size_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i) state_d = ST_ADDR;
            end
            ST_ADDR: begin
                if (arready_i) state_d = ST_DATA;   // ar handshake
            end
            ST_DATA: begin
                if (rvalid_i) state_d = ST_IDLE;    // single beat, done
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
            done_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_o  <= (state_q == ST_DATA) && rvalid_i;
        end
    end

    // request held for the whole ar phase
    always_ff @(posedge clock) begin
        if (start_i && state_q == ST_IDLE) begin
            addr_q <= addr_i;
            size_q <= size_i;
        end
        if (state_q == ST_DATA && rvalid_i) begin
            data_o <= rdata_i;
            resp_o <= rresp_i;
        end
    end

    assign arvalid_o = (state_q == ST_ADDR);
    assign araddr_o  = addr_q;
    assign arsize_o  = size_q;
    assign rready_o  = (state_q == ST_DATA);

endmodule

//--- axi_ls_lsu_pkg.sv
`include "axi_ls_config.svh"

package axi_ls_lsu_pkg;

    typedef logic [`AXLS_ADDR_W-1:0] lsu_addr_t;
    typedef logic [`AXLS_DATA_W-1:0] lsu_data_t;

    typedef enum logic [1:0] {
        LSU_BYTE  = 2'd0,
        LSU_HALF  = 2'd1,
        LSU_WORD  = 2'd2,
        LSU_DWORD = 2'd3
    } lsu_width_e;

    // one bus word seen as bytes or as half-words
    typedef union packed {
        logic [`AXLS_DATA_W-1:0]       dword;
        logic [7:0][7:0]               bytes;
        logic [3:0][15:0]              halves;
    } lsu_lanes_u;

    // strobe pattern of an access at offset zero
    function automatic logic [`AXLS_DATA_W/8-1:0] lsu_width_mask(lsu_width_e width);
        case (width)
            LSU_BYTE:  return 8'h01;
            LSU_HALF:  return 8'h03;
            LSU_WORD:  return 8'h0f;
            default:   return 8'hff;
        endcase
    endfunction

endpackage

//--- axi_ls_bus_pkg.sv
`include "axi_ls_config.svh"

package axi_ls_bus_pkg;

    typedef logic [`AXLS_ADDR_W-1:0]   axi_addr_t;
    typedef logic [`AXLS_DATA_W-1:0]   axi_data_t;
    typedef logic [`AXLS_DATA_W/8-1:0] axi_strb_t;

    // xresp encoding
    typedef logic [1:0] axi_resp_t;
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_EXOKAY = 2'b01;
    localparam axi_resp_t RESP_SLVERR = 2'b10;
    localparam axi_resp_t RESP_DECERR = 2'b11;

    // axsize, log2 of bytes per beat
    typedef logic [2:0] axi_size_t;
    localparam axi_size_t SIZE_1B = 3'd0;
    localparam axi_size_t SIZE_2B = 3'd1;
    localparam axi_size_t SIZE_4B = 3'd2;
    localparam axi_size_t SIZE_8B = 3'd3;

endpackage

//--- axi_ls_config.svh
`ifndef AXI_LS_CONFIG_SVH
`define AXI_LS_CONFIG_SVH

// bus geometry
`define AXLS_ADDR_W 32
`define AXLS_DATA_W 64

// byte offset inside one bus word
`define AXLS_OFFS_W 3

`endif
